// File: excomp_params.svh
// 32-bit datapath; the data width must be a multiple of the multiplier step bits
`ifndef EXCOMP_PARAMS_SVH
`define EXCOMP_PARAMS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// operand and result width
`define EXC_DATA_WIDTH 32
// physical register tag width
`define EXC_TAG_WIDTH 6

// multiplier bits retired per step
`define EXC_MULT_STEP_BITS 4
// steps for a full multiply
`define EXC_MULT_STEPS (`EXC_DATA_WIDTH / `EXC_MULT_STEP_BITS)

`endif

// File: excomp_pkg.sv
// types for the execute/complete slice; slot order alu0, alu1, mult with alu0 highest
`include "excomp_params.svh"

package excomp_pkg;

  ////////////////////////////////////////////////////////////
  // vectors
  ////////////////////////////////////////////////////////////

  typedef logic [`EXC_DATA_WIDTH-1:0] data_t;
  typedef logic [`EXC_TAG_WIDTH-1:0] tag_t;
  // must reach EXC_MULT_STEPS itself
  typedef logic [$clog2(`EXC_MULT_STEPS + 1)-1:0] step_count_t;

  // number of result slots on the selector
  localparam int EXC_NUM_UNITS = 3;

  ////////////////////////////////////////////////////////////
  // enums and structs
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or
  } alu_func_e;

  typedef enum logic [1:0] {
    mult_idle,
    mult_run,
    mult_hold
  } mult_state_e;

  // issued op with operands already read
  typedef struct packed {
    logic      valid;
    tag_t      tag;
    data_t     opa;
    data_t     opb;
    alu_func_e func;
  } fu_op_t;

  // one execute/complete slot
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t value;
  } fu_result_t;

  // bus uses the slot layout as is
  typedef fu_result_t cdb_t;

endpackage

// File: alu_unit.sv
// single-cycle ALU; a slot that loses arbitration holds its result and ready stays low
`timescale 1ns/1ps

module alu_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  excomp_pkg::fu_op_t     op,
  input  logic                   grant,
  output logic                   ready,
  output excomp_pkg::fu_result_t slot
);
  import excomp_pkg::*;

  logic  slot_valid;
  tag_t  slot_tag;
  data_t slot_value;
  data_t result;
  logic  accept;

  // slot free, or being drained onto the bus this cycle
  assign ready  = !slot_valid || grant;
  assign accept = op.valid && ready;

  // function decode
  always_comb begin
    unique case (op.func)
      alu_add: result = op.opa + op.opb;
      alu_sub: result = op.opa - op.opb;
      alu_and: result = op.opa & op.opb;
      alu_or:  result = op.opa | op.opb;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // execute/complete slot
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= 1'b0;
    end else if (accept) begin
      slot_valid <= 1'b1;
    end else if (grant) begin
      // drained with nothing behind it
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      slot_tag   <= op.tag;
      slot_value <= result;
    end
  end

  assign slot = '{valid: slot_valid, tag: slot_tag, value: slot_value};

  // a waiting result must reach the bus unchanged
  a_slot_held: assert property (@(posedge clock) disable iff (reset)
    (slot_valid && !grant) |=> (slot_valid && $stable(slot_tag) && $stable(slot_value)));

endmodule

// File: step_counter.sv
// counts multiply steps down from EXC_MULT_STEPS-1; holds at zero until the next load
`timescale 1ns/1ps
`include "excomp_params.svh"

module step_counter (
  input  logic clock,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last
);
  import excomp_pkg::*;

  step_count_t count;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= step_count_t'(`EXC_MULT_STEPS - 1);
    end else if (step && !last) begin
      count <= count - 1'b1;
    end
  end

  // final step in progress
  assign last = (count == '0);

  // control must not restart a multiply mid-run
  a_no_load_mid_run: assert property (@(posedge clock) disable iff (reset)
    load |-> !(step && !last));

endmodule

// File: mult_control.sv
// multiplier sequencer; a finished result waits in mult_hold until the selector grants it
`timescale 1ns/1ps

module mult_control (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    last,
  input  logic                    grant,
  output excomp_pkg::mult_state_e state,
  output logic                    load,
  output logic                    step,
  output logic                    ready
);
  import excomp_pkg::*;

  mult_state_e state_next;

  // free when idle, or when the held product leaves this cycle
  assign ready = (state == mult_idle) || ((state == mult_hold) && grant);
  assign load  = start && ready;
  assign step  = (state == mult_run);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      mult_idle: begin
        if (start) state_next = mult_run;
      end
      mult_run: begin
        // leave after the last step
        if (last) state_next = mult_hold;
      end
      mult_hold: begin
        // back to back multiplies skip idle
        if (grant) state_next = start ? mult_run : mult_idle;
      end
      default: state_next = mult_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mult_idle;
    end else begin
      state <= state_next;
    end
  end

  a_state_legal: assert property (@(posedge clock) disable iff (reset)
    state inside {mult_idle, mult_run, mult_hold});

endmodule

// File: mult_unit.sv
// shift-add multiplier; returns only the low EXC_DATA_WIDTH bits of the product
`timescale 1ns/1ps
`include "excomp_params.svh"

module mult_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  excomp_pkg::fu_op_t     op,
  input  logic                   grant,
  output logic                   ready,
  output excomp_pkg::fu_result_t slot
);
  import excomp_pkg::*;

  mult_state_e state;
  logic        load;
  logic        step;
  logic        last;

  // multiplicand, shifted up one digit per step
  data_t mcand;
  // multiplier bits not yet consumed
  data_t mplier;
  data_t prod;
  tag_t  tag_r;
  data_t step_term;

  ////////////////////////////////////////////////////////////
  // control and step count
  ////////////////////////////////////////////////////////////

  mult_control i_control (
    .clock (clock),
    .reset (reset),
    .start (op.valid),
    .last  (last),
    .grant (grant),
    .state (state),
    .load  (load),
    .step  (step),
    .ready (ready)
  );

  step_counter i_counter (
    .clock (clock),
    .reset (reset),
    .load  (load),
    .step  (step),
    .last  (last)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  // one digit of the multiplier times the shifted multiplicand
  assign step_term = mcand * data_t'(mplier[`EXC_MULT_STEP_BITS-1:0]);

  always_ff @(posedge clock) begin
    if (load) begin
      mcand  <= op.opa;
      mplier <= op.opb;
      prod   <= '0;
      tag_r  <= op.tag;
    end else if (step) begin
      prod   <= prod + step_term;
      mcand  <= mcand << `EXC_MULT_STEP_BITS;
      mplier <= mplier >> `EXC_MULT_STEP_BITS;
    end
  end

  // slot is full only once the product is complete
  assign slot = '{valid: (state == mult_hold), tag: tag_r, value: prod};

endmodule

// File: complete_select.sv
// fixed priority with alu0 highest; a slot starved by higher slots is never granted
`timescale 1ns/1ps

module complete_select (
  input  logic                                 clock,
  input  logic                                 reset,
  input  excomp_pkg::fu_result_t               alu0_slot,
  input  excomp_pkg::fu_result_t               alu1_slot,
  input  excomp_pkg::fu_result_t               mult_slot,
  output logic [excomp_pkg::EXC_NUM_UNITS-1:0] grant,
  output excomp_pkg::cdb_t                     cdb
);
  import excomp_pkg::*;

  fu_result_t [EXC_NUM_UNITS-1:0] slots;
  logic       [EXC_NUM_UNITS-1:0] req;
  fu_result_t                     sel;

  logic  cdb_valid;
  tag_t  cdb_tag;
  data_t cdb_value;

  // index order matches priority
  assign slots = {mult_slot, alu1_slot, alu0_slot};

  ////////////////////////////////////////////////////////////
  // priority grant
  ////////////////////////////////////////////////////////////

  always_comb begin
    grant = '0;
    sel   = '0;
    for (int i = 0; i < EXC_NUM_UNITS; i++) begin
      req[i] = slots[i].valid;
    end
    // walk up from lowest priority so the last hit wins
    for (int i = EXC_NUM_UNITS - 1; i >= 0; i--) begin
      if (req[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        sel      = slots[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // registered bus
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= |grant;
    end
  end

  always_ff @(posedge clock) begin
    cdb_tag   <= sel.tag;
    cdb_value <= sel.value;
  end

  assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

  a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant));
  a_grant_backed: assert property (@(posedge clock) disable iff (reset)
    (grant & ~req) == '0);

endmodule

// File: exec_complete.sv
// execute/complete top; ops must carry ready operands and tags unique while in flight
`timescale 1ns/1ps

module exec_complete (
  input  logic               clock,
  input  logic               reset,
  input  excomp_pkg::fu_op_t alu0_op,
  input  excomp_pkg::fu_op_t alu1_op,
  input  excomp_pkg::fu_op_t mult_op,
  output logic               alu0_ready,
  output logic               alu1_ready,
  output logic               mult_ready,
  output excomp_pkg::cdb_t   cdb
);
  import excomp_pkg::*;

  // slots into the selector
  fu_result_t alu0_slot;
  fu_result_t alu1_slot;
  fu_result_t mult_slot;
  // bit 0 alu0, bit 1 alu1, bit 2 mult
  logic [EXC_NUM_UNITS-1:0] grant;

  ////////////////////////////////////////////////////////////
  // functional units
  ////////////////////////////////////////////////////////////

  alu_unit i_alu0 (
    .clock (clock),
    .reset (reset),
    .op    (alu0_op),
    .grant (grant[0]),
    .ready (alu0_ready),
    .slot  (alu0_slot)
  );

  alu_unit i_alu1 (
    .clock (clock),
    .reset (reset),
    .op    (alu1_op),
    .grant (grant[1]),
    .ready (alu1_ready),
    .slot  (alu1_slot)
  );

  mult_unit i_mult (
    .clock (clock),
    .reset (reset),
    .op    (mult_op),
    .grant (grant[2]),
    .ready (mult_ready),
    .slot  (mult_slot)
  );

  // completion and bus
  complete_select i_select (
    .clock     (clock),
    .reset     (reset),
    .alu0_slot (alu0_slot),
    .alu1_slot (alu1_slot),
    .mult_slot (mult_slot),
    .grant     (grant),
    .cdb       (cdb)
  );

endmodule

// File: tb_clock_gen.sv
// free-running 8 ns clock; reset stays high for the first 4 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  // 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // release just after the fourth edge
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

// File: tb_exec_complete.sv
// assumes far fewer than 64 ops outstanding so tags stay unique; checks are concurrent assertions
`timescale 1ns/1ps
`include "excomp_params.svh"

module tb_exec_complete;
  import excomp_pkg::*;

  localparam int NUM_TAGS      = 1 << `EXC_TAG_WIDTH;
  localparam int RANDOM_CYCLES = 300;
  localparam int FLOOD_CYCLES  = 24;
  localparam int WAIT_LIMIT    = 200;

  logic       clock;
  logic       reset;
  // index 0 alu0, 1 alu1, 2 mult
  fu_op_t     op_in [3];
  logic [2:0] ready_out;
  cdb_t       cdb;

  // reference model, indexed by tag
  data_t exp_value [NUM_TAGS];
  int    accept_cycle [NUM_TAGS];
  logic  in_flight [NUM_TAGS] = '{default: 1'b0};
  logic  is_mult [NUM_TAGS] = '{default: 1'b0};
  // alu1 tag accepted together with an alu0 tag
  logic  paired [NUM_TAGS] = '{default: 1'b0};
  tag_t  partner [NUM_TAGS];

  logic [2:0]  took = '0;
  logic        mult_busy = 1'b0;
  int          cycle = 0;
  tag_t        next_tag = '0;
  int unsigned seed;
  int          errors [1:6] = '{default: 0};
  int          hits [1:6] = '{default: 0};
  int          passed = 0;
  int          failed = 0;
  string       test_name [1:6] = '{"reset_state", "cdb_value", "tag_delivery",
                                   "alu_order", "mult_busy", "slot_hold"};

  tb_clock_gen i_clock (
    .clock (clock),
    .reset (reset)
  );

  exec_complete i_dut (
    .clock      (clock),
    .reset      (reset),
    .alu0_op    (op_in[0]),
    .alu1_op    (op_in[1]),
    .mult_op    (op_in[2]),
    .alu0_ready (ready_out[0]),
    .alu1_ready (ready_out[1]),
    .mult_ready (ready_out[2]),
    .cdb        (cdb)
  );

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // ALU rules, and the low half of the product for the multiplier
  function automatic data_t expected_value(fu_op_t op, logic mult);
    if (mult) begin
      return op.opa * op.opb;
    end
    case (op.func)
      alu_add: return op.opa + op.opb;
      alu_sub: return op.opa - op.opb;
      alu_and: return op.opa & op.opb;
      default: return op.opa | op.opb;
    endcase
  endfunction

  // ops in flight plus ops still waiting at a unit input
  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      n += int'(in_flight[t]);
    end
    for (int u = 0; u < 3; u++) begin
      n += int'(op_in[u].valid);
    end
    return n;
  endfunction

  // an op not yet accepted stays on the pins unchanged
  task automatic new_op(input int u, input logic want);
    int unsigned r;
    if (took[u] || !op_in[u].valid) begin
      r = next_random();
      op_in[u].valid = want;
      op_in[u].tag   = next_tag;
      op_in[u].opa   = next_random();
      op_in[u].opb   = next_random();
      op_in[u].func  = alu_func_e'(r[29:28]);
      if (want) begin
        next_tag++;
      end
    end
  endtask

  task automatic drive_cycle(input logic [2:0] want);
    @(posedge clock);
    #1;
    for (int u = 0; u < 3; u++) begin
      new_op(u, want[u]);
    end
  endtask

  task automatic drain();
    int n;
    for (n = 0; n < WAIT_LIMIT && outstanding() != 0; n++) begin
      drive_cycle(3'b000);
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (in_flight[t]) begin
        errors[3]++;
        $display("test 3 tag_delivery: tag %0d accepted but never broadcast", t);
      end
    end
    for (int u = 0; u < 3; u++) begin
      if (op_in[u].valid) begin
        errors[3]++;
        $display("test 3 tag_delivery: unit %0d never accepted its op", u);
      end
    end
  endtask

  task automatic report_test(input int k);
    if (errors[k] == 0 && hits[k] != 0) begin
      passed++;
      $display("test %0d %s: pass", k, test_name[k]);
    end else begin
      failed++;
      if (hits[k] == 0) begin
        $display("test %0d %s: stimulus never reached the check", k, test_name[k]);
      end
      $display("test %0d %s: fail with %0d errors", k, test_name[k], errors[k]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model, updated at each edge
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    logic [2:0] acc;
    for (int u = 0; u < 3; u++) begin
      acc[u] = op_in[u].valid && ready_out[u];
    end
    cycle <= cycle + 1;
    took  <= acc;
    if (cdb.valid) begin
      in_flight[cdb.tag] <= 1'b0;
      hits[2]++;
      hits[3]++;
      if (paired[cdb.tag]) hits[4]++;
      if (is_mult[cdb.tag]) hits[5]++;
    end
    if (i_dut.alu1_slot.valid && !i_dut.grant[1]) hits[6]++;
    // a new multiply at the grant edge keeps it busy
    if (i_dut.grant[2]) mult_busy <= 1'b0;
    if (acc[2]) mult_busy <= 1'b1;
    for (int u = 0; u < 3; u++) begin
      if (acc[u]) begin
        exp_value[op_in[u].tag]    <= expected_value(op_in[u], u == 2);
        accept_cycle[op_in[u].tag] <= cycle;
        in_flight[op_in[u].tag]    <= 1'b1;
        is_mult[op_in[u].tag]      <= (u == 2);
        paired[op_in[u].tag]       <= (u == 1) && acc[0];
        partner[op_in[u].tag]      <= op_in[0].tag;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clock)
    $fell(reset) |-> (!cdb.valid && ready_out == 3'b111))
    else begin
      errors[1]++;
      $display("** Error test 1 reset_state: expected valid 0 ready 111, actual valid %0d ready %b",
               $sampled(cdb.valid), $sampled(ready_out));
    end

  a_cdb_value: assert property (@(posedge clock) disable iff (reset)
    (cdb.valid && in_flight[cdb.tag]) |-> (cdb.value == exp_value[cdb.tag]))
    else begin
      errors[2]++;
      $display("** Error test 2 cdb_value: tag %0d expected %h actual %h",
               $sampled(cdb.tag), exp_value[$sampled(cdb.tag)], $sampled(cdb.value));
    end

  a_no_duplicate: assert property (@(posedge clock) disable iff (reset)
    cdb.valid |-> in_flight[cdb.tag])
    else begin
      errors[3]++;
      $display("test 3 tag_delivery: tag %0d broadcast while not in flight", $sampled(cdb.tag));
    end

  a_alu_order: assert property (@(posedge clock) disable iff (reset)
    (cdb.valid && paired[cdb.tag]) |-> !in_flight[partner[cdb.tag]])
    else begin
      errors[4]++;
      $display("test 4 alu_order: alu1 tag %0d came out before its alu0 partner",
               $sampled(cdb.tag));
    end

  a_mult_ready: assert property (@(posedge clock) disable iff (reset)
    (mult_busy && !i_dut.grant[2]) |-> !ready_out[2])
    else begin
      errors[5]++;
      $display("test 5 mult_busy: mult_ready went high while a multiply was still in flight");
    end

  // broadcast seen one edge after the cdb register loads
  a_mult_latency: assert property (@(posedge clock) disable iff (reset)
    (cdb.valid && is_mult[cdb.tag]) |->
      ((cycle - accept_cycle[cdb.tag]) >= (`EXC_MULT_STEPS + 2)))
    else begin
      errors[5]++;
      $display("** Error test 5 mult_busy: tag %0d edges expected at least %0d actual %0d",
               $sampled(cdb.tag), `EXC_MULT_STEPS + 1,
               $sampled(cycle) - accept_cycle[$sampled(cdb.tag)] - 1);
    end

  a_alu1_ready: assert property (@(posedge clock) disable iff (reset)
    (i_dut.alu1_slot.valid && !i_dut.grant[1]) |-> !ready_out[1])
    else begin
      errors[6]++;
      $display("test 6 slot_hold: alu1 ready while its result lost the grant");
    end

  a_alu1_hold: assert property (@(posedge clock) disable iff (reset)
    (i_dut.alu1_slot.valid && !i_dut.grant[1]) |=> $stable(i_dut.alu1_slot))
    else begin
      errors[6]++;
      $display("test 6 slot_hold: alu1 slot changed while waiting for the grant");
    end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    int unsigned r;
    for (int u = 0; u < 3; u++) begin
      op_in[u] = '0;
    end
    seed = 32'd93139;
    // reset is known high from the first edge on
    @(posedge clock);
    for (n = 0; n < WAIT_LIMIT && reset; n++) begin
      @(posedge clock);
    end
    if (reset) begin
      errors[1]++;
      $display("test 1 reset_state: reset was never released");
      report_test(1);
    end else begin
      // first edge with reset low carries the reset check
      @(posedge clock);
      #1;
      hits[1] = 1;
      report_test(1);
      // random mix on all three units
      repeat (RANDOM_CYCLES) begin
        r = next_random();
        drive_cycle(3'(r >> 24));
      end
      drain();
      // alu0 every cycle starves alu1
      repeat (FLOOD_CYCLES) begin
        drive_cycle(3'b011);
      end
      drain();
    end
    for (int k = 2; k <= 6; k++) begin
      report_test(k);
    end
    $display("summary: %0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+.
excomp_pkg.sv
alu_unit.sv
step_counter.sv
mult_control.sv
mult_unit.sv
complete_select.sv
exec_complete.sv
tb_clock_gen.sv
tb_exec_complete.sv

// File: run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_exec_complete -o tb_exec_complete; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_exec_complete)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF "ALL TESTS PASSED"; then
  exit 0
fi

echo "pass message not found"
exit 1
